//--- wb_pkg.sv
`default_nettype none

package wb_pkg;

  // bus geometry of the board management Wishbone bus
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 16;

  // the upper address bits pick a block, the lower bits a register inside it
  localparam int BLOCK_W  = 4;
  localparam int OFFSET_W = 12;

  typedef struct packed {
    logic [BLOCK_W-1:0]  block;
    logic [OFFSET_W-1:0] offset;
  } wb_addr_fields_t;

  // the decoder looks at the block field, the slaves at the offset field
  typedef union packed {
    logic [ADDR_W-1:0] word;
    wb_addr_fields_t   fields;
  } wb_addr_t;

endpackage

`default_nettype wire

//--- board_pkg.sv
`default_nettype none

package board_pkg;

  // memory map block codes
  localparam logic [wb_pkg::BLOCK_W-1:0] BLK_SYS_CONFIG = wb_pkg::BLOCK_W'(0);
  localparam logic [wb_pkg::BLOCK_W-1:0] BLK_IRQ        = wb_pkg::BLOCK_W'(1);

  // system configuration block registers
  localparam logic [wb_pkg::OFFSET_W-1:0] REG_BOARD_ID = wb_pkg::OFFSET_W'(0);
  localparam logic [wb_pkg::OFFSET_W-1:0] REG_REVISION = wb_pkg::OFFSET_W'(1);
  localparam logic [wb_pkg::OFFSET_W-1:0] REG_CONFIG   = wb_pkg::OFFSET_W'(2);

  // interrupt controller registers, pending bits are cleared by writing a one
  localparam logic [wb_pkg::OFFSET_W-1:0] REG_IRQ_PENDING = wb_pkg::OFFSET_W'(0);
  localparam logic [wb_pkg::OFFSET_W-1:0] REG_IRQ_MASK    = wb_pkg::OFFSET_W'(1);

  // board identity
  localparam logic [wb_pkg::DATA_W-1:0] BOARD_ID = 16'h0B0D;
  localparam logic [wb_pkg::DATA_W-1:0] REVISION = 16'h0102;

  // configuration pin vector
  localparam int                 CONFIG_W     = 8;
  localparam logic [CONFIG_W-1:0] CONFIG_RESET = 8'h00;

  // interrupt source layout
  localparam int NUM_IRQ           = 4;
  localparam int IRQ_CHS_POWERDOWN = 0;
  localparam int IRQ_EXT_LSB       = 1;

  // kept short so a press can be seen within a few dozen clocks
  localparam int DEBOUNCE_CYCLES = 16;

endpackage

`default_nettype wire

//--- wb_slave_if.sv
`timescale 1ns/10ps
`default_nettype none

// one Wishbone classic connection between the decoder and a register slave
interface wb_slave_if;

  logic        cyc;
  logic        stb;
  logic        we;
  logic [15:0] adr;
  logic [15:0] dat_w;
  logic [15:0] dat_r;
  logic        ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- wb_addr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_addr_decode (
  input  wire logic                      gclk40,
  input  wire logic                      hard_reset,
  input  wire logic                      wb_cyc_i,
  input  wire logic                      wb_stb_i,
  input  wire logic                      wb_we_i,
  input  wire logic [wb_pkg::ADDR_W-1:0] wb_adr_i,
  input  wire logic [wb_pkg::DATA_W-1:0] wb_dat_i,
  output      logic [wb_pkg::DATA_W-1:0] wb_dat_o,
  output      logic                      wb_ack_o,
  output      logic                      wb_err_o,
  wb_slave_if.master                     cfg_bus,
  wb_slave_if.master                     irq_bus
);

  wb_pkg::wb_addr_t addr;
  logic             sel_cfg;
  logic             sel_irq;
  logic             err_req;
  logic             err_q;
  logic             err_hold;

  assign addr    = wb_adr_i;
  assign sel_cfg = (addr.fields.block == board_pkg::BLK_SYS_CONFIG);
  assign sel_irq = (addr.fields.block == board_pkg::BLK_IRQ);

  // only the strobe is steered, everything else goes to both slaves
  assign cfg_bus.cyc   = wb_cyc_i;
  assign cfg_bus.stb   = wb_stb_i & sel_cfg;
  assign cfg_bus.we    = wb_we_i;
  assign cfg_bus.adr   = wb_adr_i;
  assign cfg_bus.dat_w = wb_dat_i;

  assign irq_bus.cyc   = wb_cyc_i;
  assign irq_bus.stb   = wb_stb_i & sel_irq;
  assign irq_bus.we    = wb_we_i;
  assign irq_bus.adr   = wb_adr_i;
  assign irq_bus.dat_w = wb_dat_i;

  // the master holds the address until the cycle ends, so the select is stable here
  assign wb_dat_o = sel_cfg ? cfg_bus.dat_r :
                    sel_irq ? irq_bus.dat_r : '0;
  assign wb_ack_o = cfg_bus.ack | irq_bus.ack;

  // nobody answers an unmapped block, so the decoder ends the cycle with err
  assign err_req = wb_cyc_i & wb_stb_i & ~sel_cfg & ~sel_irq;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      err_q    <= 1'b0;
      err_hold <= 1'b0;
    end else begin
      err_q <= err_req & ~err_q & ~err_hold;
      // one err per strobe, even if the master is slow to drop it
      if (!(wb_cyc_i && wb_stb_i)) begin
        err_hold <= 1'b0;
      end else if (err_q) begin
        err_hold <= 1'b1;
      end
    end
  end

  assign wb_err_o = err_q;

endmodule

`default_nettype wire

//--- sys_config_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sys_config_regs (
  input  wire logic                           gclk40,
  input  wire logic                           hard_reset,
  wb_slave_if.slave                           bus,
  output      logic [board_pkg::CONFIG_W-1:0] sys_config_o
);

  wb_pkg::wb_addr_t                addr;
  logic                            req;
  logic                            ack_q;
  logic [board_pkg::CONFIG_W-1:0]  config_q;

  assign addr = bus.adr;

  // a new request is accepted only when no ack is out this cycle
  assign req = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      ack_q    <= 1'b0;
      config_q <= board_pkg::CONFIG_RESET;
    end else begin
      ack_q <= req;
      // identity and revision are constants, writes to them are simply acked
      if (req && bus.we && addr.fields.offset == board_pkg::REG_CONFIG) begin
        config_q <= bus.dat_w[board_pkg::CONFIG_W-1:0];
      end
    end
  end

  always_comb begin
    case (addr.fields.offset)
      board_pkg::REG_BOARD_ID: bus.dat_r = board_pkg::BOARD_ID;
      board_pkg::REG_REVISION: bus.dat_r = board_pkg::REVISION;
      board_pkg::REG_CONFIG: begin
        bus.dat_r = {{(wb_pkg::DATA_W - board_pkg::CONFIG_W){1'b0}}, config_q};
      end
      default: bus.dat_r = '0;
    endcase
  end

  assign bus.ack      = ack_q;
  assign sys_config_o = config_q;

endmodule

`default_nettype wire

//--- irq_controller.sv
`timescale 1ns/10ps
`default_nettype none

module irq_controller (
  input  wire logic                          gclk40,
  input  wire logic                          hard_reset,
  wb_slave_if.slave                          bus,
  input  wire logic [board_pkg::NUM_IRQ-1:0] irq_src_i,
  output      logic                          irq_o
);

  wb_pkg::wb_addr_t               addr;
  logic                           req;
  logic                           ack_q;
  logic [board_pkg::NUM_IRQ-1:0]  src_q;
  logic [board_pkg::NUM_IRQ-1:0]  src_qq;
  logic [board_pkg::NUM_IRQ-1:0]  src_rise;
  logic [board_pkg::NUM_IRQ-1:0]  clr;
  logic [board_pkg::NUM_IRQ-1:0]  pending_q;
  logic [board_pkg::NUM_IRQ-1:0]  mask_q;
  logic                           irq_q;

  assign addr = bus.adr;
  assign req  = bus.cyc & bus.stb & ~ack_q;

  // the first stage samples the sources, the edge is seen between the two stages
  assign src_rise = src_q & ~src_qq;

  always_comb begin
    clr = '0;
    if (req && bus.we && addr.fields.offset == board_pkg::REG_IRQ_PENDING) begin
      clr = bus.dat_w[board_pkg::NUM_IRQ-1:0];
    end
  end

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      ack_q     <= 1'b0;
      src_q     <= '0;
      src_qq    <= '0;
      pending_q <= '0;
      mask_q    <= '1;
      irq_q     <= 1'b0;
    end else begin
      ack_q  <= req;
      src_q  <= irq_src_i;
      src_qq <= src_q;
      // an edge arriving with a clear of the same bit keeps the bit set
      pending_q <= (pending_q & ~clr) | src_rise;
      if (req && bus.we && addr.fields.offset == board_pkg::REG_IRQ_MASK) begin
        mask_q <= bus.dat_w[board_pkg::NUM_IRQ-1:0];
      end
      irq_q <= |(pending_q & mask_q);
    end
  end

  always_comb begin
    case (addr.fields.offset)
      board_pkg::REG_IRQ_PENDING: begin
        bus.dat_r = {{(wb_pkg::DATA_W - board_pkg::NUM_IRQ){1'b0}}, pending_q};
      end
      board_pkg::REG_IRQ_MASK: begin
        bus.dat_r = {{(wb_pkg::DATA_W - board_pkg::NUM_IRQ){1'b0}}, mask_q};
      end
      default: bus.dat_r = '0;
    endcase
  end

  assign bus.ack = ack_q;
  assign irq_o   = irq_q;

endmodule

`default_nettype wire

//--- switch_debouncer.sv
`timescale 1ns/10ps
`default_nettype none

module switch_debouncer #(
  parameter int STABLE_CYCLES = board_pkg::DEBOUNCE_CYCLES
) (
  input  wire logic gclk40,
  input  wire logic hard_reset,
  input  wire logic switch_n_i,
  output      logic pressed_o
);

  logic [1:0]                           sync_q;
  logic                                 level_pressed;
  logic                                 pressed_q;
  logic [$clog2(STABLE_CYCLES + 1)-1:0] stable_cnt;

  // the switch is active low, a released switch reads high
  assign level_pressed = ~sync_q[1];

  always_ff @(posedge gclk40) begin
    if (hard_reset) begin
      sync_q     <= 2'b11;
      pressed_q  <= 1'b0;
      stable_cnt <= '0;
    end else begin
      sync_q <= {sync_q[0], switch_n_i};
      // count samples that disagree with the output, any agreeing sample starts over
      if (level_pressed == pressed_q) begin
        stable_cnt <= '0;
      end else if (stable_cnt == $bits(stable_cnt)'(STABLE_CYCLES - 1)) begin
        pressed_q  <= level_pressed;
        stable_cnt <= '0;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

  assign pressed_o = pressed_q;

endmodule

`default_nettype wire

//--- board_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_top (
  input  wire logic                                                   gclk40,
  input  wire logic                                                   hard_reset,
  input  wire logic                                                   wb_cyc_i,
  input  wire logic                                                   wb_stb_i,
  input  wire logic                                                   wb_we_i,
  input  wire logic [wb_pkg::ADDR_W-1:0]                              wb_adr_i,
  input  wire logic [wb_pkg::DATA_W-1:0]                              wb_dat_i,
  output      logic [wb_pkg::DATA_W-1:0]                              wb_dat_o,
  output      logic                                                   wb_ack_o,
  output      logic                                                   wb_err_o,
  input  wire logic                                                   chs_powerdown_n_i,
  input  wire logic [board_pkg::NUM_IRQ-board_pkg::IRQ_EXT_LSB-1:0]  irq_ext_i,
  output      logic                                                   irq_o,
  output      logic [board_pkg::CONFIG_W-1:0]                         sys_config_o
);

  logic                          chs_powerdown;
  logic [board_pkg::NUM_IRQ-1:0] irq_src;

  wb_slave_if cfg_bus ();
  wb_slave_if irq_bus ();

  wb_addr_decode u_decode (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .cfg_bus    (cfg_bus.master),
    .irq_bus    (irq_bus.master)
  );

  sys_config_regs u_sys_config (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .bus          (cfg_bus.slave),
    .sys_config_o (sys_config_o)
  );

  switch_debouncer #(
    .STABLE_CYCLES (board_pkg::DEBOUNCE_CYCLES)
  ) u_pwr_debounce (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .switch_n_i (chs_powerdown_n_i),
    .pressed_o  (chs_powerdown)
  );

  // the power button sits below the external fault sources
  assign irq_src[board_pkg::IRQ_CHS_POWERDOWN]                     = chs_powerdown;
  assign irq_src[board_pkg::NUM_IRQ-1:board_pkg::IRQ_EXT_LSB]      = irq_ext_i;

  irq_controller u_irq (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .bus        (irq_bus.slave),
    .irq_src_i  (irq_src),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

//--- board_ctrl_sva.sv
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_sva (
  input wire logic gclk40,
  input wire logic hard_reset,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_o,
  input wire logic wb_err_o,
  input wire logic irq_o
);

  // number of assertion failures seen so far
  int unsigned fail_count = 0;

  // a bus cycle ends with one kind of response only
  assert property (@(posedge gclk40) disable iff (hard_reset) !(wb_ack_o && wb_err_o))
    else begin
      $error("wb_ack_o and wb_err_o are high in the same cycle");
      fail_count++;
    end

  // the DUT never stalls, so a new strobe is answered on the next clock
  assert property (@(posedge gclk40) disable iff (hard_reset)
    $rose(wb_cyc_i && wb_stb_i) |=> (wb_ack_o || wb_err_o))
    else begin
      $error("strobe was not answered one cycle after it was raised");
      fail_count++;
    end

  assert property (@(posedge gclk40) hard_reset |=> !irq_o)
    else begin
      $error("irq_o is high while hard_reset is held");
      fail_count++;
    end

endmodule

bind board_ctrl_top board_ctrl_sva u_sva (
  .gclk40     (gclk40),
  .hard_reset (hard_reset),
  .wb_cyc_i   (wb_cyc_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_o   (wb_ack_o),
  .wb_err_o   (wb_err_o),
  .irq_o      (irq_o)
);

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS    = 40.0,
  parameter int  RESET_CYCLES = 3
) (
  output logic gclk40,
  output logic hard_reset
);

  initial begin
    gclk40 = 1'b0;
    forever #(PERIOD_NS / 2.0) gclk40 = ~gclk40;
  end

  // reset drops on a rising edge once RESET_CYCLES edges have passed
  initial begin
    hard_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge gclk40);
    hard_reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_board_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_board_ctrl;

  localparam int BUS_TIMEOUT = 8;

  logic        gclk40;
  logic        hard_reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [15:0] wb_dat_wr;
  logic [15:0] wb_dat_rd;
  logic        wb_ack;
  logic        wb_err;
  logic        chs_powerdown_n;
  logic [2:0]  irq_ext;
  logic        irq;
  logic [7:0]  sys_config;

  // state of the register file as the testbench expects it
  logic [7:0]  model_config;
  logic [3:0]  model_pending;
  logic [3:0]  model_mask;
  logic [31:0] lfsr_state;

  tb_clock_gen u_clk_gen (
    .gclk40     (gclk40),
    .hard_reset (hard_reset)
  );

  board_ctrl_top UUT (
    .gclk40            (gclk40),
    .hard_reset        (hard_reset),
    .wb_cyc_i          (wb_cyc),
    .wb_stb_i          (wb_stb),
    .wb_we_i           (wb_we),
    .wb_adr_i          (wb_adr),
    .wb_dat_i          (wb_dat_wr),
    .wb_dat_o          (wb_dat_rd),
    .wb_ack_o          (wb_ack),
    .wb_err_o          (wb_err),
    .chs_powerdown_n_i (chs_powerdown_n),
    .irq_ext_i         (irq_ext),
    .irq_o             (irq),
    .sys_config_o      (sys_config)
  );

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // the LFSR advances once for every bit handed out
  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = galois_step(lfsr_state);
      r = {r[14:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic wb_pkg::wb_addr_t make_addr(input int blk, input int off);
    wb_pkg::wb_addr_t a;
    a.fields.block  = wb_pkg::BLOCK_W'(blk);
    a.fields.offset = wb_pkg::OFFSET_W'(off);
    return a;
  endfunction

  // returns the expected read data of a register and lets a write update the model
  function automatic logic [15:0] ref_model(input logic we, input wb_pkg::wb_addr_t a,
                                            input logic [15:0] d);
    logic [15:0] v;
    v = '0;
    if (a.fields.block == board_pkg::BLK_SYS_CONFIG) begin
      if (we && a.fields.offset == board_pkg::REG_CONFIG) model_config = d[7:0];
      case (a.fields.offset)
        board_pkg::REG_BOARD_ID: v = board_pkg::BOARD_ID;
        board_pkg::REG_REVISION: v = board_pkg::REVISION;
        board_pkg::REG_CONFIG:   v = {8'h00, model_config};
        default:                 v = '0;
      endcase
    end else if (a.fields.block == board_pkg::BLK_IRQ) begin
      // pending bits are write-one-to-clear
      if (we && a.fields.offset == board_pkg::REG_IRQ_PENDING) model_pending &= ~d[3:0];
      if (we && a.fields.offset == board_pkg::REG_IRQ_MASK) model_mask = d[3:0];
      if (a.fields.offset == board_pkg::REG_IRQ_PENDING) v = {12'h000, model_pending};
      else if (a.fields.offset == board_pkg::REG_IRQ_MASK) v = {12'h000, model_mask};
    end
    return v;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual));
    end
  endtask

  // one Wishbone classic access where mapped blocks answer with ack and the rest with err
  task automatic bus_cycle(input logic we, input wb_pkg::wb_addr_t a,
                           input logic [15:0] wdat, output logic [15:0] rdat);
    logic [1:0] resp;
    logic       mapped;
    int         waited;
    mapped = (a.fields.block == board_pkg::BLK_SYS_CONFIG) ||
             (a.fields.block == board_pkg::BLK_IRQ);
    @(posedge gclk40);
    wb_cyc    <= 1'b1;
    wb_stb    <= 1'b1;
    wb_we     <= we;
    wb_adr    <= a.word;
    wb_dat_wr <= wdat;
    waited = 0;
    resp   = 2'b00;
    while (resp == 2'b00) begin
      @(negedge gclk40);
      resp   = {wb_err, wb_ack};
      waited = waited + 1;
      if (resp == 2'b00 && waited > BUS_TIMEOUT) begin
        stop_on_error($sformatf("no ack or err came back for address 0x%h", a.word));
      end
    end
    check_value($sformatf("{err,ack} at 0x%h", a.word), mapped ? 16'd1 : 16'd2, 16'(resp));
    rdat = wb_dat_rd;
    // the registers take the write at the ack edge, so the model follows here
    if (mapped && we) void'(ref_model(1'b1, a, wdat));
    @(posedge gclk40);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic reg_read_check(input string name, input wb_pkg::wb_addr_t a);
    logic [15:0] rdat;
    bus_cycle(1'b0, a, 16'h0000, rdat);
    check_value(name, ref_model(1'b0, a, 16'h0000), rdat);
  endtask

  task automatic wait_irq_level(input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge gclk40);
    while (irq !== level) begin
      n = n + 1;
      if (n > limit) begin
        stop_on_error($sformatf("irq_o did not reach %b within %0d cycles after %s",
                                level, limit, what));
      end
      @(negedge gclk40);
    end
  endtask

  task automatic hold_button(input int cycles);
    @(posedge gclk40);
    chs_powerdown_n <= 1'b0;
    repeat (cycles) @(posedge gclk40);
    chs_powerdown_n <= 1'b1;
  endtask

  // the configuration pins must match the model at every clock
  always @(posedge gclk40) begin
    if (!hard_reset) begin
      check_value("sys_config_o", 16'(model_config), 16'(sys_config));
    end
  end

  always @(posedge gclk40) begin
    if (UUT.u_sva.fail_count != 0) begin
      stop_on_error("a bound assertion on the bus or interrupt behavior failed");
    end
  end

  initial begin : main_sequence
    logic [15:0] data;
    logic [15:0] rdat;
    int          n;
    wb_cyc          <= 1'b0;
    wb_stb          <= 1'b0;
    wb_we           <= 1'b0;
    wb_adr          <= '0;
    wb_dat_wr       <= '0;
    chs_powerdown_n <= 1'b1;
    irq_ext         <= '0;
    model_config  = board_pkg::CONFIG_RESET;
    model_pending = '0;
    model_mask    = '1;
    lfsr_state    = 32'd70393;
    n = 0;
    while (hard_reset !== 1'b0) begin
      @(negedge gclk40);
      n = n + 1;
      if (n > 10 && hard_reset !== 1'b0) stop_on_error("hard_reset was never released");
    end
    check_value("wb_ack_o after reset", 16'h0000, 16'(wb_ack));
    check_value("wb_err_o after reset", 16'h0000, 16'(wb_err));

    // identity registers and outputs right after reset
    reg_read_check("board id", make_addr(board_pkg::BLK_SYS_CONFIG, board_pkg::REG_BOARD_ID));
    reg_read_check("revision", make_addr(board_pkg::BLK_SYS_CONFIG, board_pkg::REG_REVISION));
    reg_read_check("mask after reset", make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK));
    @(negedge gclk40);
    check_value("sys_config_o after reset", 16'(board_pkg::CONFIG_RESET), 16'(sys_config));
    check_value("irq_o after reset", 16'h0000, 16'(irq));

    // random configuration values followed by writes that the read-only registers ignore
    for (int i = 0; i < 8; i++) begin
      bus_cycle(1'b1, make_addr(board_pkg::BLK_SYS_CONFIG, board_pkg::REG_CONFIG),
                random_bits(16), rdat);
      reg_read_check("config readback",
                     make_addr(board_pkg::BLK_SYS_CONFIG, board_pkg::REG_CONFIG));
    end
    for (int off = 0; off < 2; off++) begin
      bus_cycle(1'b1, make_addr(board_pkg::BLK_SYS_CONFIG, off), random_bits(16), rdat);
      reg_read_check("read-only after write", make_addr(board_pkg::BLK_SYS_CONFIG, off));
    end

    // unmapped blocks end with err and change nothing
    for (int blk = 2; blk < 16; blk++) begin
      data = random_bits(16);
      bus_cycle(1'b1, make_addr(blk, data[11:0]), data, rdat);
      bus_cycle(1'b0, make_addr(blk, data[11:0]), 16'h0000, rdat);
    end
    reg_read_check("config after unmapped",
                   make_addr(board_pkg::BLK_SYS_CONFIG, board_pkg::REG_CONFIG));
    reg_read_check("mask after unmapped", make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK));
    reg_read_check("pending after unmapped",
                   make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));

    // a real press raises the power button interrupt
    hold_button(board_pkg::DEBOUNCE_CYCLES + 4);
    wait_irq_level(1'b1, 20, "button press");
    repeat (board_pkg::DEBOUNCE_CYCLES + 4) @(posedge gclk40);
    model_pending[board_pkg::IRQ_CHS_POWERDOWN] = 1'b1;
    reg_read_check("pending after press",
                   make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING),
              16'(1) << board_pkg::IRQ_CHS_POWERDOWN, rdat);
    wait_irq_level(1'b0, 4, "clearing the button interrupt");

    // short glitches never get through the debouncer
    for (int i = 0; i < 6; i++) begin
      data = random_bits(4);
      hold_button(1 + data % (board_pkg::DEBOUNCE_CYCLES - 3));
      data = random_bits(3);
      repeat (2 + data) @(posedge gclk40);
    end
    repeat (board_pkg::DEBOUNCE_CYCLES + 4) @(posedge gclk40);
    @(negedge gclk40);
    check_value("irq_o after glitches", 16'h0000, 16'(irq));
    reg_read_check("pending after glitches",
                   make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));

    // external sources start with only the button unmasked
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK), 16'h0001, rdat);
    @(posedge gclk40);
    irq_ext <= 3'b001;
    repeat (4) @(posedge gclk40);
    model_pending[board_pkg::IRQ_EXT_LSB] = 1'b1;
    reg_read_check("pending source 1", make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));
    @(negedge gclk40);
    check_value("irq_o with source 1 masked", 16'h0000, 16'(irq));
    // sources 1 and 3 unmasked
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK), 16'h000A, rdat);
    wait_irq_level(1'b1, 4, "unmasking source 1");
    @(posedge gclk40);
    irq_ext <= 3'b111;
    repeat (4) @(posedge gclk40);
    model_pending[3:1] = 3'b111;
    reg_read_check("pending all sources",
                   make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING), 16'h0002, rdat);
    repeat (3) @(posedge gclk40);
    @(negedge gclk40);
    check_value("irq_o with source 3 pending", 16'h0001, 16'(irq));
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING), 16'h0008, rdat);
    wait_irq_level(1'b0, 4, "clearing source 3");
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING), 16'h0004, rdat);
    reg_read_check("pending after clears",
                   make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_PENDING));
    @(posedge gclk40);
    irq_ext <= 3'b000;
    bus_cycle(1'b1, make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK), 16'h000F, rdat);
    reg_read_check("mask restored", make_addr(board_pkg::BLK_IRQ, board_pkg::REG_IRQ_MASK));

    if (UUT.u_sva.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_on_error("a bound assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

//--- tb.f
wb_pkg.sv
board_pkg.sv
wb_slave_if.sv
wb_addr_decode.sv
sys_config_regs.sv
irq_controller.sv
switch_debouncer.sv
board_ctrl_top.sv
board_ctrl_sva.sv
tb_clock_gen.sv
tb_board_ctrl.sv

//--- Bender.yml
package:
  name: board_ctrl

sources:
  - files:
      - wb_pkg.sv
      - board_pkg.sv
      - wb_slave_if.sv
      - wb_addr_decode.sv
      - sys_config_regs.sv
      - irq_controller.sv
      - switch_debouncer.sv
      - board_ctrl_top.sv
  - target: test
    files:
      - board_ctrl_sva.sv
      - tb_clock_gen.sv
      - tb_board_ctrl.sv
